// File: Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/id_consts.svh
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// Datapath and register file widths
`define ID_XLEN      32
`define ID_REG_AW    5

// Register fields inside the instruction word
`define ID_RS1_MSB   19
`define ID_RS1_LSB   15
`define ID_RS2_MSB   24
`define ID_RS2_LSB   20
`define ID_RD_MSB    11
`define ID_RD_LSB    7

// Major opcodes of the supported RV32I subset
`define ID_OPC_OP     7'b0110011
`define ID_OPC_OPIMM  7'b0010011
`define ID_OPC_LUI    7'b0110111
`define ID_OPC_AUIPC  7'b0010111
`define ID_OPC_LOAD   7'b0000011
`define ID_OPC_STORE  7'b0100011
`define ID_OPC_BRANCH 7'b1100011
`define ID_OPC_JAL    7'b1101111
`define ID_OPC_JALR   7'b1100111

// Link value added to the PC for JAL and JALR
`define ID_PC_INCR   32'd4

`endif

// File: design/id_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "id_consts.svh"

module id_decoder (
  input  wire id_pkg::word_t instr_i,
  input  wire                instr_valid_i,
  output id_pkg::dec_ctrl_t  ctrl_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Shared by OP and OP-IMM, alt selects SUB/SRA
  function automatic alu_op_e alu_op_of(logic [2:0] f3, logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // All-zero is ADD, REGA, REGB, I-immediate, nothing enabled
    ctrl_o  = '0;
    illegal = 1'b0;

    case (opcode)
      `ID_OPC_OP: begin
        ctrl_o.rega_used = 1'b1;
        ctrl_o.regb_used = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.alu_op    = alu_op_of(funct3, funct7[5]);
        illegal = (funct7 != 7'b0000000) &&
                  !((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      `ID_OPC_OPIMM: begin
        ctrl_o.rega_used = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.alu_op    = alu_op_of(funct3, funct7[5] && (funct3 == 3'b101));
        // Shift amounts only take the shamt field
        illegal = ((funct3 == 3'b001) && (funct7 != 7'b0000000)) ||
                  ((funct3 == 3'b101) && (funct7 != 7'b0000000) && (funct7 != 7'b0100000));
      end
      `ID_OPC_LUI: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
      end
      `ID_OPC_AUIPC: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_CURRPC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
      end
      `ID_OPC_LOAD: begin
        ctrl_o.rega_used     = 1'b1;
        ctrl_o.rf_we         = 1'b1;
        ctrl_o.data_req      = 1'b1;
        ctrl_o.op_b_sel      = OP_B_IMM;
        ctrl_o.data_type     = funct3[1:0];
        ctrl_o.data_sign_ext = !funct3[2];
        illegal = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
      end
      `ID_OPC_STORE: begin
        ctrl_o.rega_used = 1'b1;
        ctrl_o.regb_used = 1'b1;
        ctrl_o.data_req  = 1'b1;
        ctrl_o.data_we   = 1'b1;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_sel   = IMM_S;
        ctrl_o.data_type = funct3[1:0];
        illegal = funct3[2] || (funct3[1:0] == 2'b11);
      end
      `ID_OPC_BRANCH: begin
        ctrl_o.rega_used = 1'b1;
        ctrl_o.regb_used = 1'b1;
        ctrl_o.branch    = 1'b1;
        ctrl_o.jt_sel    = JT_COND;
        // EX compares with SUB for BEQ/BNE and SLT(U) for the rest
        case (funct3[2:1])
          2'b00:   ctrl_o.alu_op = ALU_SUB;
          2'b10:   ctrl_o.alu_op = ALU_SLT;
          2'b11:   ctrl_o.alu_op = ALU_SLTU;
          default: illegal = 1'b1;
        endcase
      end
      `ID_OPC_JAL: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_CURRPC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_PCINCR;
        ctrl_o.jt_sel   = JT_JAL;
      end
      `ID_OPC_JALR: begin
        ctrl_o.rega_used = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = OP_A_CURRPC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_sel   = IMM_PCINCR;
        ctrl_o.jt_sel    = JT_JALR;
        illegal = (funct3 != 3'b000);
      end
      default: illegal = 1'b1;
    endcase

    // Unknown or absent instruction goes down as a bubble
    if (illegal || !instr_valid_i) begin
      ctrl_o.rega_used = 1'b0;
      ctrl_o.regb_used = 1'b0;
      ctrl_o.rf_we     = 1'b0;
      ctrl_o.data_req  = 1'b0;
      ctrl_o.data_we   = 1'b0;
      ctrl_o.branch    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/id_ex_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module id_ex_pipe (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 id_valid_i,
  input  wire                 ex_ready_i,
  input  wire id_pkg::id_ex_t next_i,
  output id_pkg::id_ex_t      ex_o
);

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Zero also encodes ADD for alu_op
      ex_o <= '0;
    end else if (id_valid_i) begin
      ex_o.alu_op        <= next_i.alu_op;
      ex_o.operand_a     <= next_i.operand_a;
      ex_o.operand_b     <= next_i.operand_b;
      ex_o.rf_we         <= next_i.rf_we;
      ex_o.data_req      <= next_i.data_req;
      ex_o.data_we       <= next_i.data_we;
      ex_o.data_type     <= next_i.data_type;
      ex_o.data_sign_ext <= next_i.data_sign_ext;
      ex_o.branch_in_ex  <= next_i.branch_in_ex;

      // PC is only consumed by branch compare and LSU
      if (next_i.branch_in_ex || next_i.data_req) begin
        ex_o.pc <= next_i.pc;
      end

      if (next_i.rf_we) begin
        ex_o.waddr <= next_i.waddr;
      end
    end else if (ex_ready_i) begin
      // EX moves on without a new instruction, so send a bubble
      ex_o.rf_we        <= 1'b0;
      ex_o.data_req     <= 1'b0;
      ex_o.branch_in_ex <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/id_forward_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module id_forward_ctrl (
  input  wire id_pkg::reg_addr_t rs1_i,
  input  wire id_pkg::reg_addr_t rs2_i,
  input  wire id_pkg::dec_ctrl_t ctrl_i,
  input  wire id_pkg::id_ex_t    ex_i,
  input  wire                    alu_fw_we_i,
  input  wire id_pkg::reg_addr_t alu_fw_waddr_i,
  input  wire                    wb_we_i,
  input  wire id_pkg::reg_addr_t wb_waddr_i,
  output id_pkg::fw_sel_e        fw_a_o,
  output id_pkg::fw_sel_e        fw_b_o,
  output logic                   load_stall_o
);

  import id_pkg::*;

  logic ex_is_load;
  logic ex_hits_rs1;
  logic ex_hits_rs2;

  // ALU port is younger than writeback so it wins
  // x0 never forwards
  function automatic fw_sel_e pick_source(reg_addr_t rs, logic used);
    fw_sel_e sel;
    sel = FW_REGFILE;
    if (used && (rs != '0)) begin
      if (alu_fw_we_i && (alu_fw_waddr_i == rs)) begin
        sel = FW_ALU;
      end else if (wb_we_i && (wb_waddr_i == rs)) begin
        sel = FW_WB;
      end
    end
    return sel;
  endfunction

  always_comb begin
    fw_a_o = pick_source(rs1_i, ctrl_i.rega_used);
    fw_b_o = pick_source(rs2_i, ctrl_i.regb_used);
  end

  // Load data only arrives after EX, so a dependent instruction waits
  assign ex_is_load  = ex_i.data_req && !ex_i.data_we && ex_i.rf_we && (ex_i.waddr != '0);
  assign ex_hits_rs1 = ctrl_i.rega_used && (rs1_i == ex_i.waddr);
  assign ex_hits_rs2 = ctrl_i.regb_used && (rs2_i == ex_i.waddr);

  assign load_stall_o = ex_is_load && (ex_hits_rs1 || ex_hits_rs2);

endmodule

`default_nettype wire

// File: design/id_operand_mux.sv
`timescale 1ns/1ns
`default_nettype none

`include "id_consts.svh"

module id_operand_mux (
  input  wire id_pkg::word_t     instr_i,
  input  wire id_pkg::word_t     pc_i,
  input  wire id_pkg::word_t     rdata_a_i,
  input  wire id_pkg::word_t     rdata_b_i,
  input  wire id_pkg::word_t     alu_fw_wdata_i,
  input  wire id_pkg::word_t     wb_wdata_i,
  input  wire id_pkg::dec_ctrl_t ctrl_i,
  input  wire id_pkg::fw_sel_e   fw_a_i,
  input  wire id_pkg::fw_sel_e   fw_b_i,
  output id_pkg::word_t          operand_a_o,
  output id_pkg::word_t          operand_b_o,
  output id_pkg::word_t          jump_target_o
);

  import id_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t imm_op_b;
  word_t fw_a;
  word_t fw_b;

  //////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    case (ctrl_i.imm_sel)
      IMM_S:      imm_op_b = imm_s;
      IMM_U:      imm_op_b = imm_u;
      IMM_PCINCR: imm_op_b = `ID_PC_INCR;
      default:    imm_op_b = imm_i;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Forwarding, then operand selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (fw_a_i)
      FW_ALU:  fw_a = alu_fw_wdata_i;
      FW_WB:   fw_a = wb_wdata_i;
      default: fw_a = rdata_a_i;
    endcase
  end

  always_comb begin
    case (fw_b_i)
      FW_ALU:  fw_b = alu_fw_wdata_i;
      FW_WB:   fw_b = wb_wdata_i;
      default: fw_b = rdata_b_i;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_CURRPC: operand_a_o = pc_i;
      OP_A_ZERO:   operand_a_o = '0;
      default:     operand_a_o = fw_a;
    endcase
  end

  assign operand_b_o = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_op_b : fw_b;

  // JALR base is the raw register value, forwarding would lengthen this path
  always_comb begin
    case (ctrl_i.jt_sel)
      JT_JAL:  jump_target_o = pc_i + imm_j;
      JT_COND: jump_target_o = pc_i + imm_b;
      default: jump_target_o = rdata_a_i + imm_i;
    endcase
  end

endmodule

`default_nettype wire

// File: design/id_pkg.sv
`default_nettype none

`include "id_consts.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]   word_t;
  typedef logic [`ID_REG_AW-1:0] reg_addr_t;

  // LSU access size, same encoding as funct3[1:0]
  typedef logic [1:0] mem_type_t;

  // ADD must stay at zero, it is the reset value in EX
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REGA, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REGB, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;
  typedef enum logic [1:0] {JT_JAL, JT_COND, JT_JALR} jt_sel_e;
  typedef enum logic [1:0] {FW_ALU, FW_WB, FW_REGFILE} fw_sel_e;

  // Decoder output for one instruction
  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    imm_sel_e  imm_sel;
    jt_sel_e   jt_sel;
    logic      rega_used;
    logic      regb_used;
    logic      rf_we;
    logic      data_req;
    logic      data_we;
    mem_type_t data_type;
    logic      data_sign_ext;
    logic      branch;
  } dec_ctrl_t;

  // Contents of the ID/EX register
  typedef struct packed {
    alu_op_e   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    word_t     pc;
    reg_addr_t waddr;
    logic      rf_we;
    logic      data_req;
    logic      data_we;
    mem_type_t data_type;
    logic      data_sign_ext;
    logic      branch_in_ex;
  } id_ex_t;

endpackage

`default_nettype wire

// File: design/id_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module id_regfile (
  input  wire                clk,
  input  wire                rst_n,
  input  wire id_pkg::reg_addr_t raddr_a_i,
  input  wire id_pkg::reg_addr_t raddr_b_i,
  output id_pkg::word_t      rdata_a_o,
  output id_pkg::word_t      rdata_b_o,
  input  wire                we_i,
  input  wire id_pkg::reg_addr_t waddr_i,
  input  wire id_pkg::word_t wdata_i
);

  // x0 has no storage
  id_pkg::word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: design/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "id_consts.svh"

module id_stage (
  input  wire                    clk,
  input  wire                    rst_n,
  // Fetch side
  input  wire                    instr_valid_i,
  input  wire id_pkg::word_t     instr_i,
  input  wire id_pkg::word_t     pc_i,
  // Writeback write port
  input  wire                    wb_we_i,
  input  wire id_pkg::reg_addr_t wb_waddr_i,
  input  wire id_pkg::word_t     wb_wdata_i,
  // EX ALU result, forward only
  input  wire                    alu_fw_we_i,
  input  wire id_pkg::reg_addr_t alu_fw_waddr_i,
  input  wire id_pkg::word_t     alu_fw_wdata_i,
  input  wire                    ex_ready_i,
  output logic                   id_ready_o,
  output logic                   id_valid_o,
  output id_pkg::id_ex_t         ex_o,
  output id_pkg::word_t          jump_target_o
);

  import id_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     rdata_a;
  word_t     rdata_b;
  word_t     operand_a;
  word_t     operand_b;
  dec_ctrl_t dec_ctrl;
  fw_sel_e   fw_a;
  fw_sel_e   fw_b;
  logic      load_stall;
  id_ex_t    id_next;

  assign rs1 = instr_i[`ID_RS1_MSB:`ID_RS1_LSB];
  assign rs2 = instr_i[`ID_RS2_MSB:`ID_RS2_LSB];
  assign rd  = instr_i[`ID_RD_MSB:`ID_RD_LSB];

  id_regfile regfile_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (wb_we_i),
    .waddr_i   (wb_waddr_i),
    .wdata_i   (wb_wdata_i)
  );

  id_decoder decoder_i (
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .ctrl_o        (dec_ctrl)
  );

  id_forward_ctrl forward_ctrl_i (
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .ctrl_i         (dec_ctrl),
    .ex_i           (ex_o),
    .alu_fw_we_i    (alu_fw_we_i),
    .alu_fw_waddr_i (alu_fw_waddr_i),
    .wb_we_i        (wb_we_i),
    .wb_waddr_i     (wb_waddr_i),
    .fw_a_o         (fw_a),
    .fw_b_o         (fw_b),
    .load_stall_o   (load_stall)
  );

  id_operand_mux operand_mux_i (
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .alu_fw_wdata_i (alu_fw_wdata_i),
    .wb_wdata_i     (wb_wdata_i),
    .ctrl_i         (dec_ctrl),
    .fw_a_i         (fw_a),
    .fw_b_i         (fw_b),
    .operand_a_o    (operand_a),
    .operand_b_o    (operand_b),
    .jump_target_o  (jump_target_o)
  );

  assign id_next = '{
    alu_op:        dec_ctrl.alu_op,
    operand_a:     operand_a,
    operand_b:     operand_b,
    pc:            pc_i,
    waddr:         rd,
    rf_we:         dec_ctrl.rf_we,
    data_req:      dec_ctrl.data_req,
    data_we:       dec_ctrl.data_we,
    data_type:     dec_ctrl.data_type,
    data_sign_ext: dec_ctrl.data_sign_ext,
    branch_in_ex:  dec_ctrl.branch
  };

  id_ex_pipe ex_pipe_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_valid_i (id_valid_o),
    .ex_ready_i (ex_ready_i),
    .next_i     (id_next),
    .ex_o       (ex_o)
  );

  // Stage handshake
  assign id_ready_o = !load_stall && ex_ready_i;
  assign id_valid_o = instr_valid_i && id_ready_o;

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/id_pkg.sv
design/id_regfile.sv
design/id_decoder.sv
design/id_forward_ctrl.sv
design/id_operand_mux.sv
design/id_ex_pipe.sv
design/id_stage.sv
verif/id_tb_clkgen.sv
verif/id_stage_tb.sv

// File: verif/id_stage_golden.hex
// First word is the vector count. Then per vector, stimulus then expected values:
// instr pc iv_er wbwe_addr wbdata afwe_addr afdata rdy_jtchk jt alu opa opb pc wa flags
17
00000000 00000000 01 101 00001000 000 00000000 10 00000000 0 00000000 00000000 00000000 00 000000
00000000 00000000 01 102 00000024 000 00000000 10 00000000 0 00000000 00000000 00000000 00 000000
00000000 00000000 01 103 fffffff0 000 00000000 10 00000000 0 00000000 00000000 00000000 00 000000
00208233 00000100 11 000 00000000 000 00000000 10 00000000 0 00001000 00000024 00000000 04 100000
fff18293 00000104 11 000 00000000 000 00000000 10 00000000 0 fffffff0 ffffffff 00000000 05 100000
40208333 00000108 11 101 55550000 101 aaaa0000 10 00000000 1 aaaa0000 00000024 00000000 06 100000
0020f3b3 0000010c 11 102 0000ff00 105 12345678 10 00000000 2 55550000 0000ff00 00000000 07 100000
00206433 00000110 11 100 cafef00d 100 deadbeef 10 00000000 3 00000000 0000ff00 00000000 08 100000
123454b7 00000114 11 000 00000000 000 00000000 10 00000000 0 00000000 12345000 00000000 09 100000
fffff517 00000118 11 000 00000000 000 00000000 10 00000000 0 00000118 fffff000 00000000 0a 100000
fe20ac23 0000011c 11 000 00000000 000 00000000 10 00000000 0 55550000 fffffff8 0000011c 0a 011200
001000ef 00000120 11 000 00000000 000 00000000 11 00000920 0 00000120 00000004 0000011c 01 100000
010102e7 00000124 11 000 00000000 000 00000000 11 0000ff10 0 00000124 00000004 0000011c 05 100000
fe2088e3 00000128 11 000 00000000 000 00000000 11 00000118 1 55550000 0000ff00 00000128 05 000001
0011e463 0000012c 11 000 00000000 000 00000000 11 00000134 6 fffffff0 55550000 0000012c 05 000001
0040a583 00000130 11 000 00000000 000 00000000 10 00000000 0 55550000 00000004 00000130 0b 110210
00258633 00000134 11 000 00000000 000 00000000 00 00000000 0 55550000 00000004 00000130 0b 000210
00258633 00000134 11 10b 0badc0de 000 00000000 10 00000000 0 0badc0de 0000ff00 00000130 0c 100000
0030c6b3 00000138 10 000 00000000 000 00000000 00 00000000 0 0badc0de 0000ff00 00000130 0c 100000
0030c6b3 00000138 10 000 00000000 000 00000000 00 00000000 0 0badc0de 0000ff00 00000130 0c 100000
0030c6b3 00000138 11 000 00000000 000 00000000 10 00000000 4 55550000 fffffff0 00000130 0d 100000
4041d713 0000013c 11 000 00000000 000 00000000 10 00000000 9 fffffff0 00000404 00000130 0e 100000
ffffffff 00000140 11 000 00000000 000 00000000 10 00000000 0 00000000 00000000 00000130 0e 000000

// File: verif/id_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage_tb;

  import id_pkg::*;

  localparam int VEC_WORDS = 15;
  localparam int MAX_VECS  = 64;

  logic      clk;
  logic      rst_n;
  logic      instr_valid;
  word_t     instr;
  word_t     pc;
  logic      wb_we;
  reg_addr_t wb_waddr;
  word_t     wb_wdata;
  logic      alu_fw_we;
  reg_addr_t alu_fw_waddr;
  word_t     alu_fw_wdata;
  logic      ex_ready;
  logic      id_ready;
  logic      id_valid;
  id_ex_t    ex_out;
  word_t     jump_target;

  // Word 0 holds the vector count and each vector then takes VEC_WORDS words
  logic [31:0] golden [0:MAX_VECS*VEC_WORDS];
  int          vec_count = 0;

  id_tb_clkgen clkgen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  id_stage dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .pc_i           (pc),
    .wb_we_i        (wb_we),
    .wb_waddr_i     (wb_waddr),
    .wb_wdata_i     (wb_wdata),
    .alu_fw_we_i    (alu_fw_we),
    .alu_fw_waddr_i (alu_fw_waddr),
    .alu_fw_wdata_i (alu_fw_wdata),
    .ex_ready_i     (ex_ready),
    .id_ready_o     (id_ready),
    .id_valid_o     (id_valid),
    .ex_o           (ex_out),
    .jump_target_o  (jump_target)
  );

  //////////////////////////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(string test, string field, logic [31:0] expected,
                             logic [31:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("FAILED %s %s: expected %h, actual %h",
                                  test, field, expected, actual));
    end
  endtask

  task automatic check_ex(string test, id_ex_t expected);
    check_value(test, "alu_op", 32'(expected.alu_op), 32'(ex_out.alu_op));
    check_value(test, "operand_a", expected.operand_a, ex_out.operand_a);
    check_value(test, "operand_b", expected.operand_b, ex_out.operand_b);
    check_value(test, "pc", expected.pc, ex_out.pc);
    check_value(test, "waddr", 32'(expected.waddr), 32'(ex_out.waddr));
    check_value(test, "rf_we", 32'(expected.rf_we), 32'(ex_out.rf_we));
    check_value(test, "data_req", 32'(expected.data_req), 32'(ex_out.data_req));
    check_value(test, "data_we", 32'(expected.data_we), 32'(ex_out.data_we));
    check_value(test, "data_type", 32'(expected.data_type), 32'(ex_out.data_type));
    check_value(test, "data_sign_ext", 32'(expected.data_sign_ext),
                32'(ex_out.data_sign_ext));
    check_value(test, "branch_in_ex", 32'(expected.branch_in_ex),
                32'(ex_out.branch_in_ex));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Vector decoding
  //////////////////////////////////////////////////////////////////////

  // Flag nibbles hold rf_we data_req data_we data_type sign_ext branch
  function automatic id_ex_t expected_ex(int base);
    id_ex_t      e;
    logic [31:0] flags;
    flags           = golden[base+14];
    e.alu_op        = alu_op_e'(golden[base+9][3:0]);
    e.operand_a     = golden[base+10];
    e.operand_b     = golden[base+11];
    e.pc            = golden[base+12];
    e.waddr         = golden[base+13][4:0];
    e.rf_we         = flags[20];
    e.data_req      = flags[16];
    e.data_we       = flags[12];
    e.data_type     = flags[9:8];
    e.data_sign_ext = flags[4];
    e.branch_in_ex  = flags[0];
    return e;
  endfunction

  task automatic drive_vector(int base);
    logic [31:0] hs;
    logic [31:0] wb;
    logic [31:0] af;
    hs           = golden[base+2];
    wb           = golden[base+3];
    af           = golden[base+5];
    instr        = golden[base];
    pc           = golden[base+1];
    instr_valid  = hs[4];
    ex_ready     = hs[0];
    wb_we        = wb[8];
    wb_waddr     = wb[4:0];
    wb_wdata     = golden[base+4];
    alu_fw_we    = af[8];
    alu_fw_waddr = af[4:0];
    alu_fw_wdata = golden[base+6];
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          base;
    string       test;
    logic [31:0] hs_tok;
    logic [31:0] rdy_tok;

    instr_valid  = 1'b0;
    instr        = '0;
    pc           = '0;
    wb_we        = 1'b0;
    wb_waddr     = '0;
    wb_wdata     = '0;
    alu_fw_we    = 1'b0;
    alu_fw_waddr = '0;
    alu_fw_wdata = '0;
    ex_ready     = 1'b0;

    $readmemh("verif/id_stage_golden.hex", golden);
    if ($isunknown(golden[0]) || (golden[0] == 0) || (golden[0] > MAX_VECS)) begin
      stop_with_failure("Golden file is missing or its vector count is out of range");
    end
    vec_count = int'(golden[0]);

    @(posedge rst_n);
    check_ex("reset", '0);

    for (int i = 0; i < vec_count; i++) begin
      base = 1 + i * VEC_WORDS;
      test = $sformatf("vector %0d", i);
      drive_vector(base);

      // Combinational outputs settle well before the falling edge
      @(negedge clk);
      hs_tok  = golden[base+2];
      rdy_tok = golden[base+7];
      check_value(test, "id_ready", 32'(rdy_tok[4]), 32'(id_ready));
      // Handshake rule: valid only when fetch offers and ID can accept
      check_value(test, "id_valid", 32'(hs_tok[4] && rdy_tok[4]), 32'(id_valid));
      if (rdy_tok[0]) begin
        check_value(test, "jump_target", golden[base+8], jump_target);
      end

      @(posedge clk);
      #1;
      check_ex(test, expected_ex(base));
    end

    $display("** PASS **");
    $finish;
  end

  // Reset plus one cycle per vector and some slack
  initial begin
    wait (vec_count != 0);
    #((vec_count + 10) * 10);
    stop_with_failure("Timeout: the vectors did not complete in the expected time");
  end

endmodule

`default_nettype wire

// File: verif/id_tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module id_tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset low over the first three rising edges, released just after the third
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire
